//--- filelist.f
source/tcdm_pkg.sv
source/cc_regmap_pkg.sv
source/spill_register.sv
source/tcdm_id_remapper.sv
source/cc_ctrl_regs.sv
source/cc_mem_top.sv
tb/tcdm_mem_model.sv
tb/cc_mem_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the memory-side testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  --top-module cc_mem_tb -f filelist.f -o sim_cc_mem \
  && ./obj_dir/sim_cc_mem \
  || { echo "Simulation build or run failed"; exit 1; }

//--- source/cc_ctrl_regs.sv
// ------------------------------
// Control and counter registers
// Wishbone classic slave with FP enable and traffic counters
// ------------------------------
module cc_ctrl_regs (
  input  logic                             clk_i,
  input  logic                             rst_i,
  // Wishbone
  input  logic                             wb_cyc_i,
  input  logic                             wb_stb_i,
  input  logic                             wb_we_i,
  input  logic [cc_regmap_pkg::WB_AW-1:0]   wb_adr_i,
  input  logic [cc_regmap_pkg::WB_DW-1:0]   wb_dat_i,
  input  logic [cc_regmap_pkg::WB_DW/8-1:0] wb_sel_i,
  output logic [cc_regmap_pkg::WB_DW-1:0]   wb_dat_o,
  output logic                             wb_ack_o,
  // Events
  input  logic                             grant_core_i,
  input  logic                             grant_fp_i,
  input  logic                             tcdm_q_valid_i,
  input  logic                             tcdm_q_ready_i,
  output logic                             fp_en_o
);
  import cc_regmap_pkg::*;

  logic             access, wr_en, stall;
  logic             ack_q, ctrl_q;
  logic [CNT_W-1:0] cnt_core_q, cnt_fp_q, cnt_stall_q;
  logic [WB_DW-1:0] rdata;

  // One access per strobe, never back to back
  assign access = wb_cyc_i && wb_stb_i && !ack_q;
  assign wr_en  = access && wb_we_i;
  assign stall  = tcdm_q_valid_i && !tcdm_q_ready_i;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      ack_q  <= 1'b0;
      ctrl_q <= CTRL_RESET;
    end else begin
      ack_q <= access;
      if (wr_en && wb_adr_i == REG_CTRL && wb_sel_i[0]) begin
        ctrl_q <= wb_dat_i[0];
      end
    end
  end

  // ------------------------------
  // Counters, cleared by any write
  // ------------------------------
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      cnt_core_q  <= '0;
      cnt_fp_q    <= '0;
      cnt_stall_q <= '0;
    end else begin
      if (wr_en && wb_adr_i == REG_CNT_CORE) begin
        cnt_core_q <= '0;
      end else if (grant_core_i) begin
        cnt_core_q <= cnt_core_q + 1'b1;
      end
      if (wr_en && wb_adr_i == REG_CNT_FP) begin
        cnt_fp_q <= '0;
      end else if (grant_fp_i) begin
        cnt_fp_q <= cnt_fp_q + 1'b1;
      end
      if (wr_en && wb_adr_i == REG_CNT_STALL) begin
        cnt_stall_q <= '0;
      end else if (stall) begin
        cnt_stall_q <= cnt_stall_q + 1'b1;
      end
    end
  end

  // Read mux
  always_comb begin
    case (wb_adr_i)
      REG_CTRL:      rdata = {{(WB_DW-1){1'b0}}, ctrl_q};
      REG_CNT_CORE:  rdata = WB_DW'(cnt_core_q);
      REG_CNT_FP:    rdata = WB_DW'(cnt_fp_q);
      REG_CNT_STALL: rdata = WB_DW'(cnt_stall_q);
      default:       rdata = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (access) begin
      wb_dat_o <= rdata;
    end
  end

  assign wb_ack_o = ack_q;
  assign fp_en_o  = ctrl_q;

  // Master holds the strobe until it sees the ack
  assert property (@(posedge clk_i) disable iff (rst_i)
    wb_cyc_i && wb_stb_i && !wb_ack_o |=> wb_cyc_i && wb_stb_i)
    else $error("cc_ctrl_regs: strobe dropped before ack");

endmodule

//--- source/cc_mem_top.sv
// ------------------------------
// Core complex memory side
// Remapper, TCDM slices and control block
// ------------------------------
module cc_mem_top (
  input  logic                             clk_i,
  input  logic                             rst_i,
  // Core requestor
  input  logic [tcdm_pkg::ADDR_W-1:0]       core_q_addr_i,
  input  logic                             core_q_write_i,
  input  logic [tcdm_pkg::DATA_W-1:0]       core_q_data_i,
  input  logic [tcdm_pkg::STRB_W-1:0]       core_q_strb_i,
  input  logic [tcdm_pkg::ID_W-1:0]         core_q_id_i,
  input  logic                             core_q_valid_i,
  output logic                             core_q_ready_o,
  output logic [tcdm_pkg::DATA_W-1:0]       core_p_data_o,
  output logic [tcdm_pkg::ID_W-1:0]         core_p_id_o,
  output logic                             core_p_error_o,
  output logic                             core_p_valid_o,
  input  logic                             core_p_ready_i,
  // FP requestor
  input  logic [tcdm_pkg::ADDR_W-1:0]       fp_q_addr_i,
  input  logic                             fp_q_write_i,
  input  logic [tcdm_pkg::DATA_W-1:0]       fp_q_data_i,
  input  logic [tcdm_pkg::STRB_W-1:0]       fp_q_strb_i,
  input  logic [tcdm_pkg::ID_W-1:0]         fp_q_id_i,
  input  logic                             fp_q_valid_i,
  output logic                             fp_q_ready_o,
  output logic [tcdm_pkg::DATA_W-1:0]       fp_p_data_o,
  output logic [tcdm_pkg::ID_W-1:0]         fp_p_id_o,
  output logic                             fp_p_error_o,
  output logic                             fp_p_valid_o,
  input  logic                             fp_p_ready_i,
  // TCDM port
  output logic [tcdm_pkg::ADDR_W-1:0]       tcdm_q_addr_o,
  output logic                             tcdm_q_write_o,
  output logic [tcdm_pkg::DATA_W-1:0]       tcdm_q_data_o,
  output logic [tcdm_pkg::STRB_W-1:0]       tcdm_q_strb_o,
  output logic [tcdm_pkg::REMAP_W-1:0]      tcdm_q_id_o,
  output logic                             tcdm_q_valid_o,
  input  logic                             tcdm_q_ready_i,
  input  logic [tcdm_pkg::DATA_W-1:0]       tcdm_p_data_i,
  input  logic [tcdm_pkg::REMAP_W-1:0]      tcdm_p_id_i,
  input  logic                             tcdm_p_error_i,
  input  logic                             tcdm_p_valid_i,
  output logic                             tcdm_p_ready_o,
  // Wishbone
  input  logic                             wb_cyc_i,
  input  logic                             wb_stb_i,
  input  logic                             wb_we_i,
  input  logic [cc_regmap_pkg::WB_AW-1:0]   wb_adr_i,
  input  logic [cc_regmap_pkg::WB_DW-1:0]   wb_dat_i,
  input  logic [cc_regmap_pkg::WB_DW/8-1:0] wb_sel_i,
  output logic [cc_regmap_pkg::WB_DW-1:0]   wb_dat_o,
  output logic                             wb_ack_o
);
  import tcdm_pkg::*;

  tcdm_req_t req_d, req_q;
  tcdm_rsp_t rsp_d, rsp_q;
  logic      req_d_valid, req_d_ready;
  logic      rsp_q_valid, rsp_q_ready;
  logic      grant_core, grant_fp, fp_en;

  tcdm_id_remapper remapper_i (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .fp_en_i        (fp_en),
    .core_q_addr_i  (core_q_addr_i),
    .core_q_write_i (core_q_write_i),
    .core_q_data_i  (core_q_data_i),
    .core_q_strb_i  (core_q_strb_i),
    .core_q_id_i    (core_q_id_i),
    .core_q_valid_i (core_q_valid_i),
    .core_q_ready_o (core_q_ready_o),
    .core_p_data_o  (core_p_data_o),
    .core_p_id_o    (core_p_id_o),
    .core_p_error_o (core_p_error_o),
    .core_p_valid_o (core_p_valid_o),
    .core_p_ready_i (core_p_ready_i),
    .fp_q_addr_i    (fp_q_addr_i),
    .fp_q_write_i   (fp_q_write_i),
    .fp_q_data_i    (fp_q_data_i),
    .fp_q_strb_i    (fp_q_strb_i),
    .fp_q_id_i      (fp_q_id_i),
    .fp_q_valid_i   (fp_q_valid_i),
    .fp_q_ready_o   (fp_q_ready_o),
    .fp_p_data_o    (fp_p_data_o),
    .fp_p_id_o      (fp_p_id_o),
    .fp_p_error_o   (fp_p_error_o),
    .fp_p_valid_o   (fp_p_valid_o),
    .fp_p_ready_i   (fp_p_ready_i),
    .req_o          (req_d),
    .req_valid_o    (req_d_valid),
    .req_ready_i    (req_d_ready),
    .rsp_i          (rsp_q),
    .rsp_valid_i    (rsp_q_valid),
    .rsp_ready_o    (rsp_q_ready),
    .grant_core_o   (grant_core),
    .grant_fp_o     (grant_fp)
  );

  // ------------------------------
  // TCDM request and response cuts
  // ------------------------------
  spill_register #(
    .T      (tcdm_req_t),
    .BYPASS (!REG_TCDM_REQ)
  ) spill_req_i (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .valid_i (req_d_valid),
    .ready_o (req_d_ready),
    .data_i  (req_d),
    .valid_o (tcdm_q_valid_o),
    .ready_i (tcdm_q_ready_i),
    .data_o  (req_q)
  );

  assign rsp_d = '{data: tcdm_p_data_i, id: tcdm_p_id_i, error: tcdm_p_error_i};

  spill_register #(
    .T      (tcdm_rsp_t),
    .BYPASS (!REG_TCDM_RSP)
  ) spill_rsp_i (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .valid_i (tcdm_p_valid_i),
    .ready_o (tcdm_p_ready_o),
    .data_i  (rsp_d),
    .valid_o (rsp_q_valid),
    .ready_i (rsp_q_ready),
    .data_o  (rsp_q)
  );

  assign tcdm_q_addr_o  = req_q.addr;
  assign tcdm_q_write_o = req_q.write;
  assign tcdm_q_data_o  = req_q.data;
  assign tcdm_q_strb_o  = req_q.strb;
  assign tcdm_q_id_o    = req_q.id;

  cc_ctrl_regs ctrl_regs_i (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .wb_cyc_i       (wb_cyc_i),
    .wb_stb_i       (wb_stb_i),
    .wb_we_i        (wb_we_i),
    .wb_adr_i       (wb_adr_i),
    .wb_dat_i       (wb_dat_i),
    .wb_sel_i       (wb_sel_i),
    .wb_dat_o       (wb_dat_o),
    .wb_ack_o       (wb_ack_o),
    .grant_core_i   (grant_core),
    .grant_fp_i     (grant_fp),
    .tcdm_q_valid_i (tcdm_q_valid_o),
    .tcdm_q_ready_i (tcdm_q_ready_i),
    .fp_en_o        (fp_en)
  );

endmodule

//--- source/cc_regmap_pkg.sv
// ------------------------------
// Control block register map
// Wishbone widths and register offsets
// ------------------------------
package cc_regmap_pkg;

  localparam int unsigned WB_AW = 4;
  localparam int unsigned WB_DW = 32;

  // Byte offsets
  localparam logic [WB_AW-1:0] REG_CTRL      = 4'h0;
  localparam logic [WB_AW-1:0] REG_CNT_CORE  = 4'h4;
  localparam logic [WB_AW-1:0] REG_CNT_FP    = 4'h8;
  localparam logic [WB_AW-1:0] REG_CNT_STALL = 4'hc;

  // FP port enabled out of reset
  localparam logic CTRL_RESET = 1'b1;

  localparam int unsigned CNT_W = 32;

endpackage

//--- source/spill_register.sv
// ------------------------------
// Spill register
// Two-slot valid/ready slice for any payload type
// ------------------------------
module spill_register #(
  parameter type T      = logic,
  parameter bit  BYPASS = 1'b0
) (
  input  logic clk_i,
  input  logic rst_i,
  input  logic valid_i,
  output logic ready_o,
  input  T     data_i,
  output logic valid_o,
  input  logic ready_i,
  output T     data_o
);

  if (BYPASS) begin : gen_bypass
    assign valid_o = valid_i;
    assign ready_o = ready_i;
    assign data_o  = data_i;
  end else begin : gen_reg
    logic a_full_q, b_full_q;
    logic a_fill, a_drain, b_fill, b_drain;
    T     a_data_q, b_data_q;

    // Slot a takes new items, slot b holds the older one on a stall
    assign a_fill  = valid_i && ready_o;
    assign a_drain = a_full_q && !b_full_q;
    assign b_fill  = a_drain && !ready_i;
    assign b_drain = b_full_q && ready_i;

    always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
        a_full_q <= 1'b0;
        b_full_q <= 1'b0;
      end else begin
        a_full_q <= a_fill || (a_full_q && !a_drain);
        b_full_q <= b_fill || (b_full_q && !b_drain);
      end
    end

    always_ff @(posedge clk_i) begin
      if (a_fill) begin
        a_data_q <= data_i;
      end
      if (b_fill) begin
        b_data_q <= a_data_q;
      end
    end

    assign valid_o = a_full_q || b_full_q;
    assign ready_o = !a_full_q || !b_full_q;
    assign data_o  = b_full_q ? b_data_q : a_data_q;

    // Output must not change while stalled
    assert property (@(posedge clk_i) disable iff (rst_i)
      valid_o && !ready_i |=> $stable(data_o))
      else $error("spill_register: data_o changed under back-pressure");
  end

endmodule

//--- source/tcdm_id_remapper.sv
// ------------------------------
// TCDM ID remapper
// Merges core and FP requestors onto one TCDM port
// ------------------------------
module tcdm_id_remapper (
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  logic                        fp_en_i,
  // Core requestor
  input  logic [tcdm_pkg::ADDR_W-1:0] core_q_addr_i,
  input  logic                        core_q_write_i,
  input  logic [tcdm_pkg::DATA_W-1:0] core_q_data_i,
  input  logic [tcdm_pkg::STRB_W-1:0] core_q_strb_i,
  input  logic [tcdm_pkg::ID_W-1:0]   core_q_id_i,
  input  logic                        core_q_valid_i,
  output logic                        core_q_ready_o,
  output logic [tcdm_pkg::DATA_W-1:0] core_p_data_o,
  output logic [tcdm_pkg::ID_W-1:0]   core_p_id_o,
  output logic                        core_p_error_o,
  output logic                        core_p_valid_o,
  input  logic                        core_p_ready_i,
  // FP requestor
  input  logic [tcdm_pkg::ADDR_W-1:0] fp_q_addr_i,
  input  logic                        fp_q_write_i,
  input  logic [tcdm_pkg::DATA_W-1:0] fp_q_data_i,
  input  logic [tcdm_pkg::STRB_W-1:0] fp_q_strb_i,
  input  logic [tcdm_pkg::ID_W-1:0]   fp_q_id_i,
  input  logic                        fp_q_valid_i,
  output logic                        fp_q_ready_o,
  output logic [tcdm_pkg::DATA_W-1:0] fp_p_data_o,
  output logic [tcdm_pkg::ID_W-1:0]   fp_p_id_o,
  output logic                        fp_p_error_o,
  output logic                        fp_p_valid_o,
  input  logic                        fp_p_ready_i,
  // TCDM side
  output tcdm_pkg::tcdm_req_t         req_o,
  output logic                        req_valid_o,
  input  logic                        req_ready_i,
  input  tcdm_pkg::tcdm_rsp_t         rsp_i,
  input  logic                        rsp_valid_i,
  output logic                        rsp_ready_o,
  // Event strobes
  output logic                        grant_core_o,
  output logic                        grant_fp_o
);
  import tcdm_pkg::*;

  logic [NUM_REMAP-1:0] busy_q;
  logic [NUM_REMAP-1:0] origin_q;
  logic [ID_W-1:0]      orig_id_q [NUM_REMAP];
  logic [REMAP_W-1:0]   free_idx;
  logic                 any_free;
  logic                 core_req, fp_req, sel_fp, rr_q, grant;
  logic                 rsp_fp, rsp_fire;

  // Lowest free table entry
  always_comb begin
    free_idx = '0;
    any_free = 1'b0;
    for (int i = NUM_REMAP - 1; i >= 0; i--) begin
      if (!busy_q[i]) begin
        free_idx = REMAP_W'(i);
        any_free = 1'b1;
      end
    end
  end

  // ------------------------------
  // Request path
  // ------------------------------
  assign core_req = core_q_valid_i;
  assign fp_req   = fp_q_valid_i && fp_en_i;

  // rr_q set gives the FP port priority
  assign sel_fp      = fp_req && (!core_req || rr_q);
  assign req_valid_o = (core_req || fp_req) && any_free;
  assign grant       = req_valid_o && req_ready_i;

  always_comb begin
    if (sel_fp) begin
      req_o.addr  = fp_q_addr_i;
      req_o.write = fp_q_write_i;
      req_o.data  = fp_q_data_i;
      req_o.strb  = fp_q_strb_i;
    end else begin
      req_o.addr  = core_q_addr_i;
      req_o.write = core_q_write_i;
      req_o.data  = core_q_data_i;
      req_o.strb  = core_q_strb_i;
    end
    req_o.id = free_idx;
  end

  assign core_q_ready_o = grant && !sel_fp;
  assign fp_q_ready_o   = grant && sel_fp;
  assign grant_core_o   = core_q_valid_i && core_q_ready_o;
  assign grant_fp_o     = fp_q_valid_i && fp_q_ready_o;

  // ------------------------------
  // Response path
  // ------------------------------
  assign rsp_fp      = origin_q[rsp_i.id];
  assign rsp_ready_o = rsp_fp ? fp_p_ready_i : core_p_ready_i;
  assign rsp_fire    = rsp_valid_i && rsp_ready_o;

  assign core_p_valid_o = rsp_valid_i && !rsp_fp;
  assign core_p_data_o  = rsp_i.data;
  assign core_p_id_o    = orig_id_q[rsp_i.id];
  assign core_p_error_o = rsp_i.error;

  assign fp_p_valid_o = rsp_valid_i && rsp_fp;
  assign fp_p_data_o  = rsp_i.data;
  assign fp_p_id_o    = orig_id_q[rsp_i.id];
  assign fp_p_error_o = rsp_i.error;

  // Alloc and free never hit the same entry
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      busy_q <= '0;
      rr_q   <= 1'b0;
    end else begin
      if (rsp_fire) begin
        busy_q[rsp_i.id] <= 1'b0;
      end
      if (grant) begin
        busy_q[free_idx] <= 1'b1;
        rr_q             <= !sel_fp;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (grant) begin
      origin_q[free_idx]  <= sel_fp;
      orig_id_q[free_idx] <= sel_fp ? fp_q_id_i : core_q_id_i;
    end
  end

  assert property (@(posedge clk_i) disable iff (rst_i)
    rsp_valid_i |-> busy_q[rsp_i.id])
    else $error("tcdm_id_remapper: response for a free remap entry");

  // Priority moves to the other port after each grant
  assert property (@(posedge clk_i) disable iff (rst_i)
    $past(grant) && grant && core_req && fp_req |-> sel_fp != $past(sel_fp))
    else $error("tcdm_id_remapper: round-robin priority did not move");

endmodule

//--- source/tcdm_pkg.sv
// ------------------------------
// TCDM package
// Memory-side widths, remap sizing and payload structs
// ------------------------------
package tcdm_pkg;

  // Requestor and memory widths
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;
  localparam int unsigned STRB_W = 4;
  localparam int unsigned ID_W   = 3;

  // Remap table, one entry per outstanding request
  localparam int unsigned NUM_REMAP = 4;
  localparam int unsigned REMAP_W   = 2;

  // Register slices on the TCDM side
  localparam bit REG_TCDM_REQ = 1'b1;
  localparam bit REG_TCDM_RSP = 1'b1;

  // ------------------------------
  // Payloads
  // ------------------------------
  typedef struct packed {
    logic [ADDR_W-1:0]  addr;
    logic               write;
    logic [DATA_W-1:0]  data;
    logic [STRB_W-1:0]  strb;
    logic [REMAP_W-1:0] id;
  } tcdm_req_t;

  typedef struct packed {
    logic [DATA_W-1:0]  data;
    logic [REMAP_W-1:0] id;
    logic               error;
  } tcdm_rsp_t;

endpackage

//--- tb/cc_mem_tb.sv
// ------------------------------
// Core complex memory testbench
// Two requestors, TCDM model, Wishbone checks
// ------------------------------
module cc_mem_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import tcdm_pkg::*;
  import cc_regmap_pkg::*;

  localparam int N_MIX   = 40;
  localparam int NUM_TXN = 2 * N_MIX + 40;
  localparam int EXP_W   = DATA_W + ID_W + 1;

  logic                clk_i, rst_i;
  logic [ADDR_W-1:0]   q_addr [2];
  logic [DATA_W-1:0]   q_data [2];
  logic [STRB_W-1:0]   q_strb [2];
  logic [ID_W-1:0]     q_id [2];
  logic                q_write [2], q_valid [2], q_ready [2];
  logic [DATA_W-1:0]   p_data [2];
  logic [ID_W-1:0]     p_id [2];
  logic                p_error [2], p_valid [2], p_ready [2];
  logic [ADDR_W-1:0]   tcdm_q_addr;
  logic [DATA_W-1:0]   tcdm_q_data, tcdm_p_data;
  logic [STRB_W-1:0]   tcdm_q_strb;
  logic [REMAP_W-1:0]  tcdm_q_id, tcdm_p_id;
  logic                tcdm_q_write, tcdm_q_valid, tcdm_q_ready;
  logic                tcdm_p_error, tcdm_p_valid, tcdm_p_ready;
  logic                wb_cyc, wb_stb, wb_we, wb_ack, mem_err, fp_off;
  logic [WB_AW-1:0]    wb_adr;
  logic [WB_DW-1:0]    wb_dat_w, wb_dat_r, rd;
  logic [WB_DW/8-1:0]  wb_sel;

  int                  seed = 32'h27b5_77e9;
  logic [DATA_W-1:0]   ref_mem [logic [ADDR_W-1:0]];
  // {is_read, id, data} per port, in issue order
  logic [EXP_W-1:0]    exp_q [2][$];
  logic [EXP_W:0]      front [2];
  logic                p_fire [2];
  logic                t_q_fire, t_p_fire;
  int                  grants [2];
  int                  stall_cnt, outstanding;

  cc_mem_top cc_mem_top_i (
    .clk_i (clk_i), .rst_i (rst_i),
    .core_q_addr_i (q_addr[0]), .core_q_write_i (q_write[0]), .core_q_data_i (q_data[0]),
    .core_q_strb_i (q_strb[0]), .core_q_id_i (q_id[0]), .core_q_valid_i (q_valid[0]),
    .core_q_ready_o (q_ready[0]), .core_p_data_o (p_data[0]), .core_p_id_o (p_id[0]),
    .core_p_error_o (p_error[0]), .core_p_valid_o (p_valid[0]), .core_p_ready_i (p_ready[0]),
    .fp_q_addr_i (q_addr[1]), .fp_q_write_i (q_write[1]), .fp_q_data_i (q_data[1]),
    .fp_q_strb_i (q_strb[1]), .fp_q_id_i (q_id[1]), .fp_q_valid_i (q_valid[1]),
    .fp_q_ready_o (q_ready[1]), .fp_p_data_o (p_data[1]), .fp_p_id_o (p_id[1]),
    .fp_p_error_o (p_error[1]), .fp_p_valid_o (p_valid[1]), .fp_p_ready_i (p_ready[1]),
    .tcdm_q_addr_o (tcdm_q_addr), .tcdm_q_write_o (tcdm_q_write),
    .tcdm_q_data_o (tcdm_q_data), .tcdm_q_strb_o (tcdm_q_strb), .tcdm_q_id_o (tcdm_q_id),
    .tcdm_q_valid_o (tcdm_q_valid), .tcdm_q_ready_i (tcdm_q_ready),
    .tcdm_p_data_i (tcdm_p_data), .tcdm_p_id_i (tcdm_p_id), .tcdm_p_error_i (tcdm_p_error),
    .tcdm_p_valid_i (tcdm_p_valid), .tcdm_p_ready_o (tcdm_p_ready),
    .wb_cyc_i (wb_cyc), .wb_stb_i (wb_stb), .wb_we_i (wb_we), .wb_adr_i (wb_adr),
    .wb_dat_i (wb_dat_w), .wb_sel_i (wb_sel), .wb_dat_o (wb_dat_r), .wb_ack_o (wb_ack)
  );

  tcdm_mem_model mem_i (
    .clk_i (clk_i), .rst_i (rst_i),
    .q_addr_i (tcdm_q_addr), .q_write_i (tcdm_q_write), .q_data_i (tcdm_q_data),
    .q_strb_i (tcdm_q_strb), .q_id_i (tcdm_q_id), .q_valid_i (tcdm_q_valid),
    .q_ready_o (tcdm_q_ready), .p_data_o (tcdm_p_data), .p_id_o (tcdm_p_id),
    .p_error_o (tcdm_p_error), .p_valid_o (tcdm_p_valid), .p_ready_i (tcdm_p_ready),
    .proto_err_o (mem_err)
  );

  task automatic report_failure(input string msg);
    $display("[FAIL] %0t: %s", $time, msg);
    $display("Test failed");
    $fatal(1, "Stopped on the first error");
  endtask

  function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_w,
      input logic [DATA_W-1:0] new_w, input logic [STRB_W-1:0] strb);
    logic [DATA_W-1:0] w;
    w = old_w;
    for (int b = 0; b < STRB_W; b++) begin
      if (strb[b]) begin
        w[8*b +: 8] = new_w[8*b +: 8];
      end
    end
    return w;
  endfunction

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  initial begin
    repeat (200 * NUM_TXN) @(posedge clk_i);
    $display("Watchdog timeout, the tests did not finish in time");
    $display("Test failed");
    $fatal(1, "Watchdog expired");
  end

  // ------------------------------
  // Monitors
  // ------------------------------
  always @(negedge clk_i) begin
    p_fire[0] = p_valid[0] && p_ready[0];
    p_fire[1] = p_valid[1] && p_ready[1];
    t_q_fire  = tcdm_q_valid && tcdm_q_ready;
    t_p_fire  = tcdm_p_valid && tcdm_p_ready;
    if (tcdm_q_valid && !tcdm_q_ready) begin
      stall_cnt++;
    end
  end

  always @(posedge clk_i) begin
    for (int p = 0; p < 2; p++) begin
      if (p_fire[p]) begin
        void'(exp_q[p].pop_front());
      end
      front[p] = exp_q[p].size() > 0 ? {1'b1, exp_q[p][0]} : '0;
    end
    outstanding = outstanding + int'(t_q_fire) - int'(t_p_fire);
  end

  assert property (@(negedge clk_i) disable iff (rst_i)
    p_valid[0] && p_ready[0] |-> front[0][EXP_W] && !p_error[0]
      && p_id[0] == front[0][DATA_W +: ID_W]
      && (!front[0][EXP_W-1] || p_data[0] == front[0][DATA_W-1:0]))
    else report_failure("core response does not match the reference");

  assert property (@(negedge clk_i) disable iff (rst_i)
    p_valid[1] && p_ready[1] |-> front[1][EXP_W] && !p_error[1]
      && p_id[1] == front[1][DATA_W +: ID_W]
      && (!front[1][EXP_W-1] || p_data[1] == front[1][DATA_W-1:0]))
    else report_failure("FP response does not match the reference");

  assert property (@(negedge clk_i) disable iff (rst_i)
    tcdm_q_valid |-> outstanding < int'(NUM_REMAP))
    else report_failure("TCDM request with all remap IDs outstanding");

  assert property (@(negedge clk_i) disable iff (rst_i)
    wb_stb && !wb_ack |=> wb_ack)
    else report_failure("Wishbone ack not one cycle after strobe");

  assert property (@(negedge clk_i) disable iff (rst_i)
    wb_ack |=> !wb_ack)
    else report_failure("Wishbone ack longer than one cycle");

  assert property (@(negedge clk_i) disable iff (rst_i) fp_off |-> !q_ready[1])
    else report_failure("FP request accepted while the port is disabled");

  assert property (@(negedge clk_i) disable iff (rst_i) !mem_err)
    else report_failure("TCDM request changed while stalled");

  // ------------------------------
  // Stimulus tasks, entered and left just after a rising edge
  // ------------------------------
  task automatic send_req(input int p, input logic wr, input logic [ADDR_W-1:0] a,
      input logic [DATA_W-1:0] d, input logic [STRB_W-1:0] s, input logic [ID_W-1:0] id);
    logic [DATA_W-1:0] cur;
    q_addr[p]  = a;
    q_write[p] = wr;
    q_data[p]  = d;
    q_strb[p]  = s;
    q_id[p]    = id;
    q_valid[p] = 1'b1;
    do @(negedge clk_i); while (!q_ready[p]);
    cur = ref_mem.exists(a) ? ref_mem[a] : '0;
    if (wr) begin
      ref_mem[a] = merge_bytes(cur, d, s);
      exp_q[p].push_back({1'b0, id, DATA_W'(0)});
    end else begin
      exp_q[p].push_back({1'b1, id, cur});
    end
    grants[p]++;
    @(posedge clk_i);
    #1;
    q_valid[p] = 1'b0;
  endtask

  // Each port stays in its own address region
  task automatic port_traffic(input int p, input int n);
    logic [31:0] r;
    repeat (n) begin
      r = $random(seed);
      repeat (int'(r[17:16])) begin
        @(posedge clk_i);
        #1;
      end
      send_req(p, r[8], {23'd0, p[0], r[5:0], 2'b00}, $random(seed), r[12:9], r[15:13]);
    end
  endtask

  // Pending requests count as not drained
  task automatic wait_drained();
    do @(negedge clk_i);
    while (q_valid[0] || q_valid[1] || outstanding != 0
           || exp_q[0].size() > 0 || exp_q[1].size() > 0);
    @(posedge clk_i);
    #1;
  endtask

  task automatic wb_access(input logic we, input logic [WB_AW-1:0] adr,
      input logic [WB_DW-1:0] dat, output logic [WB_DW-1:0] rdat);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = dat;
    wb_sel   = '1;
    do @(negedge clk_i); while (!wb_ack);
    rdat = wb_dat_r;
    @(posedge clk_i);
    #1;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic check_reg(input logic [WB_AW-1:0] adr, input int expected, input string msg);
    logic [WB_DW-1:0] v;
    wb_access(1'b0, adr, '0, v);
    assert (v == WB_DW'(expected)) else report_failure(msg);
  endtask

  initial begin : ready_gen
    logic [31:0] r;
    p_ready[0] = 1'b0;
    p_ready[1] = 1'b0;
    @(negedge rst_i);
    forever begin
      r = $random(seed);
      p_ready[0] = r[1:0] != 2'b00;
      p_ready[1] = r[3:2] != 2'b00;
      @(posedge clk_i);
      #1;
    end
  end

  initial begin
    for (int p = 0; p < 2; p++) begin
      q_addr[p] = '0;
      q_write[p] = 1'b0;
      q_data[p] = '0;
      q_strb[p] = '0;
      q_id[p] = '0;
      q_valid[p] = 1'b0;
      p_fire[p] = 1'b0;
      front[p] = '0;
      grants[p] = 0;
    end
    {t_q_fire, t_p_fire, fp_off} = 3'b000;
    {wb_cyc, wb_stb, wb_we} = 3'b000;
    wb_adr = '0;
    wb_dat_w = '0;
    wb_sel = '0;
    stall_cnt = 0;
    outstanding = 0;
    rst_i = 1'b1;
    repeat (2) @(posedge clk_i);
    #1;
    rst_i = 1'b0;

    @(negedge clk_i);
    assert (!tcdm_q_valid && !p_valid[0] && !p_valid[1] && !wb_ack)
      else report_failure("outputs not idle after reset");
    @(posedge clk_i);
    #1;
    check_reg(REG_CTRL, int'(CTRL_RESET), "REG_CTRL reset value wrong");

    send_req(0, 1'b1, 32'h40, 32'h1234_5678, 4'hf, 3'd3);
    send_req(0, 1'b0, 32'h40, '0, 4'hf, 3'd3);
    wait_drained();

    fork
      port_traffic(0, N_MIX);
      port_traffic(1, N_MIX);
    join
    wait_drained();

    // FP port off, core keeps going
    wb_access(1'b1, REG_CTRL, '0, rd);
    fp_off = 1'b1;
    fork
      send_req(1, 1'b0, 32'h100, '0, 4'hf, 3'd5);
    join_none
    send_req(0, 1'b1, 32'h80, 32'hcafe_f00d, 4'hf, 3'd1);
    send_req(0, 1'b0, 32'h80, '0, 4'hf, 3'd2);
    do @(negedge clk_i); while (exp_q[0].size() > 0);
    repeat (10) @(posedge clk_i);
    #1;
    fp_off = 1'b0;
    wb_access(1'b1, REG_CTRL, 32'h1, rd);
    wait_drained();

    check_reg(REG_CNT_CORE, grants[0], "core grant counter wrong");
    check_reg(REG_CNT_FP, grants[1], "FP grant counter wrong");
    check_reg(REG_CNT_STALL, stall_cnt, "stall counter wrong");
    wb_access(1'b1, REG_CNT_CORE, '0, rd);
    wb_access(1'b1, REG_CNT_FP, '0, rd);
    wb_access(1'b1, REG_CNT_STALL, '0, rd);
    check_reg(REG_CNT_CORE, 0, "core grant counter not cleared");
    check_reg(REG_CNT_FP, 0, "FP grant counter not cleared");
    check_reg(REG_CNT_STALL, 0, "stall counter not cleared");

    $display("Test passed");
    $finish;
  end

endmodule

//--- tb/tcdm_mem_model.sv
// ------------------------------
// Behavioural TCDM
// Random back-pressure, in-order responses
// ------------------------------
module tcdm_mem_model (
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  logic [tcdm_pkg::ADDR_W-1:0]  q_addr_i,
  input  logic                        q_write_i,
  input  logic [tcdm_pkg::DATA_W-1:0]  q_data_i,
  input  logic [tcdm_pkg::STRB_W-1:0]  q_strb_i,
  input  logic [tcdm_pkg::REMAP_W-1:0] q_id_i,
  input  logic                        q_valid_i,
  output logic                        q_ready_o,
  output logic [tcdm_pkg::DATA_W-1:0]  p_data_o,
  output logic [tcdm_pkg::REMAP_W-1:0] p_id_o,
  output logic                        p_error_o,
  output logic                        p_valid_o,
  input  logic                        p_ready_i,
  output logic                        proto_err_o
);
  timeunit 1ns;
  timeprecision 1ps;
  import tcdm_pkg::*;

  logic [DATA_W-1:0]         mem [logic [ADDR_W-1:0]];
  logic [DATA_W+REMAP_W-1:0] rsp_q [$];
  logic [DATA_W-1:0]         word;
  logic                      q_fire, p_fire;
  int                        seed = 32'h27b5_77e9;

  initial begin
    q_ready_o   = 1'b0;
    p_valid_o   = 1'b0;
    p_data_o    = '0;
    p_id_o      = '0;
    p_error_o   = 1'b0;
    proto_err_o = 1'b0;
    forever begin
      // Transfers are decided at the falling edge, applied after the rising one
      @(negedge clk_i);
      q_fire = q_valid_i && q_ready_o && !rst_i;
      p_fire = p_valid_o && p_ready_i && !rst_i;
      if (q_fire) begin
        word = mem.exists(q_addr_i) ? mem[q_addr_i] : '0;
        if (q_write_i) begin
          for (int b = 0; b < STRB_W; b++) begin
            if (q_strb_i[b]) begin
              word[8*b +: 8] = q_data_i[8*b +: 8];
            end
          end
          mem[q_addr_i] = word;
          rsp_q.push_back({DATA_W'(0), q_id_i});
        end else begin
          rsp_q.push_back({word, q_id_i});
        end
      end
      @(posedge clk_i);
      #1;
      if (p_fire) begin
        p_valid_o = 1'b0;
        void'(rsp_q.pop_front());
      end
      q_ready_o = ($random(seed) & 3) != 0;
      if (!p_valid_o && rsp_q.size() > 0 && ($random(seed) & 1) == 0) begin
        {p_data_o, p_id_o} = rsp_q[0];
        p_valid_o = 1'b1;
      end
    end
  end

  // Requests hold still while stalled
  assert property (@(negedge clk_i) disable iff (rst_i)
    q_valid_i && !q_ready_o |=> q_valid_i && $stable(q_addr_i))
    else proto_err_o = 1'b1;

endmodule
